// File: design/dcache_pkg.sv
// dcache shared widths, geometry, field types and controller states
`default_nettype none

package dcache_pkg;

    // word and address widths
    localparam int WORD_W     = 32;
    localparam int ADDR_W     = 32;
    localparam int BYTE_OFF_W = 2;
    localparam int BLK_OFF_W  = 1;
    localparam int IDX_W      = 3;
    localparam int TAG_W      = ADDR_W - IDX_W - BLK_OFF_W - BYTE_OFF_W;

    // two-way geometry, one LRU bit per set
    localparam int NUM_SETS    = 1 << IDX_W;
    localparam int NUM_WAYS    = 2;
    localparam int NUM_FRAMES  = NUM_SETS * NUM_WAYS;
    // extra msb lets the flush walker step past the last frame
    localparam int FRAME_IDX_W = $clog2(NUM_FRAMES) + 1;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [IDX_W-1:0]  idx_t;

    // address layout msb to lsb: tag, index, block offset, byte offset
    typedef enum logic [3:0] {
        IDLE,
        WRITEBACK1,
        WRITEBACK2,
        LOAD1,
        LOAD2,
        FLUSH_CHECK,
        FLUSH_WB1,
        FLUSH_WB2,
        FLUSHED
    } dcache_state_e;

endpackage

`default_nettype wire

// File: design/dcache_array.sv
// dcache storage for tags, data, valid, dirty and LRU with tag compare
`timescale 1ns/1ps
`default_nettype none

module dcache_array import dcache_pkg::*; (
    input  logic  CLK,
    input  logic  nRST,
    // lookup side
    input  idx_t  lookup_idx,
    input  tag_t  lookup_tag,
    output logic  hit,
    output logic  hit_way,
    output logic  lru_way,
    // frame read
    input  logic  rd_way,
    output logic  rd_valid,
    output logic  rd_dirty,
    output tag_t  rd_tag,
    output word_t rd_data0,
    output word_t rd_data1,
    // frame and LRU write
    input  logic  wr_en,
    input  idx_t  wr_idx,
    input  logic  wr_way,
    input  logic  wr_valid,
    input  logic  wr_dirty,
    input  tag_t  wr_tag,
    input  word_t wr_data0,
    input  word_t wr_data1,
    input  logic  wr_lru
);

    logic  valid_q [NUM_SETS][NUM_WAYS];
    logic  dirty_q [NUM_SETS][NUM_WAYS];
    tag_t  tag_q   [NUM_SETS][NUM_WAYS];
    word_t data0_q [NUM_SETS][NUM_WAYS];
    word_t data1_q [NUM_SETS][NUM_WAYS];
    // points at the way to evict next
    logic  lru_q   [NUM_SETS];

    logic match0;
    logic match1;

    // compare both ways of the indexed set
    assign match0 = valid_q[lookup_idx][0] && (tag_q[lookup_idx][0] == lookup_tag);
    assign match1 = valid_q[lookup_idx][1] && (tag_q[lookup_idx][1] == lookup_tag);

    assign hit     = match0 || match1;
    assign hit_way = match1;
    assign lru_way = lru_q[lookup_idx];

    // selected frame, combinational
    assign rd_valid = valid_q[lookup_idx][rd_way];
    assign rd_dirty = dirty_q[lookup_idx][rd_way];
    assign rd_tag   = tag_q[lookup_idx][rd_way];
    assign rd_data0 = data0_q[lookup_idx][rd_way];
    assign rd_data1 = data1_q[lookup_idx][rd_way];

    // one frame plus the set's LRU bit per cycle
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                lru_q[s] <= 1'b0;
                for (int w = 0; w < NUM_WAYS; w++) begin
                    valid_q[s][w] <= 1'b0;
                    dirty_q[s][w] <= 1'b0;
                    tag_q[s][w]   <= '0;
                    data0_q[s][w] <= '0;
                    data1_q[s][w] <= '0;
                end
            end
        end else if (wr_en) begin
            valid_q[wr_idx][wr_way] <= wr_valid;
            dirty_q[wr_idx][wr_way] <= wr_dirty;
            tag_q[wr_idx][wr_way]   <= wr_tag;
            data0_q[wr_idx][wr_way] <= wr_data0;
            data1_q[wr_idx][wr_way] <= wr_data1;
            lru_q[wr_idx]           <= wr_lru;
        end
    end

endmodule

`default_nettype wire

// File: design/dcache_ctrl.sv
// dcache controller FSM for hits, victim write-back, refill and flush on halt
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl import dcache_pkg::*; (
    input  logic  CLK,
    input  logic  nRST,
    // CPU side
    input  logic  dmem_ren,
    input  logic  dmem_wen,
    input  addr_t dmem_addr,
    input  word_t dmem_store,
    input  logic  halt,
    output logic  dhit,
    output word_t dmem_load,
    output logic  flushed,
    // memory bus
    output logic  mem_ren,
    output logic  mem_wen,
    output addr_t mem_addr,
    output word_t mem_store,
    input  word_t mem_load,
    input  logic  mem_wait,
    // array lookup and read
    output idx_t  lookup_idx,
    output tag_t  lookup_tag,
    input  logic  hit,
    input  logic  hit_way,
    input  logic  lru_way,
    output logic  rd_way,
    input  logic  rd_valid,
    input  logic  rd_dirty,
    input  tag_t  rd_tag,
    input  word_t rd_data0,
    input  word_t rd_data1,
    // array write
    output logic  wr_en,
    output idx_t  wr_idx,
    output logic  wr_way,
    output logic  wr_valid,
    output logic  wr_dirty,
    output tag_t  wr_tag,
    output word_t wr_data0,
    output word_t wr_data1,
    output logic  wr_lru
);

    dcache_state_e state, next_state;

    logic [FRAME_IDX_W-1:0] flush_cnt, next_flush_cnt;
    logic flushed_q;

    tag_t cpu_tag;
    idx_t cpu_idx;
    logic cpu_blk;
    logic cpu_req;
    logic flush_mode;
    logic flush_done;

    // split the CPU address
    assign cpu_tag = dmem_addr[ADDR_W-1 -: TAG_W];
    assign cpu_idx = dmem_addr[BYTE_OFF_W + BLK_OFF_W +: IDX_W];
    assign cpu_blk = dmem_addr[BYTE_OFF_W];
    assign cpu_req = dmem_ren || dmem_wen;

    assign flush_mode = (state == FLUSH_CHECK) || (state == FLUSH_WB1)
                     || (state == FLUSH_WB2);
    assign flush_done = (flush_cnt == FRAME_IDX_W'(NUM_FRAMES));

    // the walker takes over index and way during the flush
    assign lookup_idx = flush_mode ? flush_cnt[IDX_W-1:0] : cpu_idx;
    assign lookup_tag = cpu_tag;
    assign rd_way = flush_mode ? flush_cnt[IDX_W]
                  : ((state == IDLE) && hit) ? hit_way : lru_way;

    assign dhit      = (state == IDLE) && cpu_req && hit && !halt;
    assign dmem_load = cpu_blk ? rd_data1 : rd_data0;
    assign flushed   = flushed_q;

    // next state and flush walker
    always_comb begin
        next_state     = state;
        next_flush_cnt = flush_cnt;
        case (state)
            IDLE: begin
                if (halt) begin
                    next_state = FLUSH_CHECK;
                end else if (cpu_req && !hit) begin
                    // victim is the LRU way
                    next_state = rd_dirty ? WRITEBACK1 : LOAD1;
                end
            end
            WRITEBACK1:  if (!mem_wait) next_state = WRITEBACK2;
            WRITEBACK2:  if (!mem_wait) next_state = LOAD1;
            LOAD1:       if (!mem_wait) next_state = LOAD2;
            LOAD2:       if (!mem_wait) next_state = IDLE;
            FLUSH_CHECK: begin
                if (flush_done) begin
                    next_state = FLUSHED;
                end else if (rd_valid && rd_dirty) begin
                    next_state = FLUSH_WB1;
                end else begin
                    next_flush_cnt = flush_cnt + 1'b1;
                end
            end
            FLUSH_WB1:   if (!mem_wait) next_state = FLUSH_WB2;
            FLUSH_WB2: begin
                if (!mem_wait) begin
                    next_state     = FLUSH_CHECK;
                    next_flush_cnt = flush_cnt + 1'b1;
                end
            end
            FLUSHED:     next_state = FLUSHED;
            default:     next_state = IDLE;
        endcase
    end

    // bus requests and table updates
    always_comb begin
        mem_ren   = 1'b0;
        mem_wen   = 1'b0;
        mem_addr  = '0;
        mem_store = '0;
        // by default rewrite the selected frame unchanged
        wr_en    = 1'b0;
        wr_idx   = lookup_idx;
        wr_way   = rd_way;
        wr_valid = rd_valid;
        wr_dirty = rd_dirty;
        wr_tag   = rd_tag;
        wr_data0 = rd_data0;
        wr_data1 = rd_data1;
        wr_lru   = lru_way;
        case (state)
            IDLE: begin
                if (dhit) begin
                    wr_en  = 1'b1;
                    wr_lru = ~hit_way;
                    if (dmem_wen) begin
                        wr_dirty = 1'b1;
                        if (cpu_blk) begin
                            wr_data1 = dmem_store;
                        end else begin
                            wr_data0 = dmem_store;
                        end
                    end
                end
            end
            WRITEBACK1, FLUSH_WB1: begin
                mem_wen   = 1'b1;
                mem_addr  = {rd_tag, lookup_idx, 1'b0, {BYTE_OFF_W{1'b0}}};
                mem_store = rd_data0;
            end
            WRITEBACK2, FLUSH_WB2: begin
                mem_wen   = 1'b1;
                mem_addr  = {rd_tag, lookup_idx, 1'b1, {BYTE_OFF_W{1'b0}}};
                mem_store = rd_data1;
                // flushed frames are dropped once written out
                if ((state == FLUSH_WB2) && !mem_wait) begin
                    wr_en    = 1'b1;
                    wr_valid = 1'b0;
                    wr_dirty = 1'b0;
                end
            end
            LOAD1: begin
                mem_ren  = 1'b1;
                mem_addr = {cpu_tag, cpu_idx, 1'b0, {BYTE_OFF_W{1'b0}}};
                if (!mem_wait) begin
                    // half filled, keep it invalid
                    wr_en    = 1'b1;
                    wr_valid = 1'b0;
                    wr_dirty = 1'b0;
                    wr_tag   = cpu_tag;
                    wr_data0 = mem_load;
                end
            end
            LOAD2: begin
                mem_ren  = 1'b1;
                mem_addr = {cpu_tag, cpu_idx, 1'b1, {BYTE_OFF_W{1'b0}}};
                if (!mem_wait) begin
                    wr_en    = 1'b1;
                    wr_valid = 1'b1;
                    wr_dirty = 1'b0;
                    wr_tag   = cpu_tag;
                    wr_data1 = mem_load;
                end
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= IDLE;
            flush_cnt <= '0;
            flushed_q <= 1'b0;
        end else begin
            state     <= next_state;
            flush_cnt <= next_flush_cnt;
            flushed_q <= (next_state == FLUSHED);
        end
    end

endmodule

`default_nettype wire

// File: design/dcache_top.sv
// dcache top level joining the storage array and its controller
`timescale 1ns/1ps
`default_nettype none

module dcache_top import dcache_pkg::*; (
    input  logic  CLK,
    input  logic  nRST,
    // CPU side
    input  logic  dmem_ren,
    input  logic  dmem_wen,
    input  addr_t dmem_addr,
    input  word_t dmem_store,
    input  logic  halt,
    output logic  dhit,
    output word_t dmem_load,
    output logic  flushed,
    // memory bus
    output logic  mem_ren,
    output logic  mem_wen,
    output addr_t mem_addr,
    output word_t mem_store,
    input  word_t mem_load,
    input  logic  mem_wait
);

    idx_t  lookup_idx;
    tag_t  lookup_tag;
    logic  hit;
    logic  hit_way;
    logic  lru_way;
    logic  rd_way;
    logic  rd_valid;
    logic  rd_dirty;
    tag_t  rd_tag;
    word_t rd_data0;
    word_t rd_data1;
    logic  wr_en;
    idx_t  wr_idx;
    logic  wr_way;
    logic  wr_valid;
    logic  wr_dirty;
    tag_t  wr_tag;
    word_t wr_data0;
    word_t wr_data1;
    logic  wr_lru;

    dcache_array u_array (
        .CLK        (CLK),
        .nRST       (nRST),
        .lookup_idx (lookup_idx),
        .lookup_tag (lookup_tag),
        .hit        (hit),
        .hit_way    (hit_way),
        .lru_way    (lru_way),
        .rd_way     (rd_way),
        .rd_valid   (rd_valid),
        .rd_dirty   (rd_dirty),
        .rd_tag     (rd_tag),
        .rd_data0   (rd_data0),
        .rd_data1   (rd_data1),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .wr_way     (wr_way),
        .wr_valid   (wr_valid),
        .wr_dirty   (wr_dirty),
        .wr_tag     (wr_tag),
        .wr_data0   (wr_data0),
        .wr_data1   (wr_data1),
        .wr_lru     (wr_lru)
    );

    dcache_ctrl u_ctrl (
        .CLK        (CLK),
        .nRST       (nRST),
        .dmem_ren   (dmem_ren),
        .dmem_wen   (dmem_wen),
        .dmem_addr  (dmem_addr),
        .dmem_store (dmem_store),
        .halt       (halt),
        .dhit       (dhit),
        .dmem_load  (dmem_load),
        .flushed    (flushed),
        .mem_ren    (mem_ren),
        .mem_wen    (mem_wen),
        .mem_addr   (mem_addr),
        .mem_store  (mem_store),
        .mem_load   (mem_load),
        .mem_wait   (mem_wait),
        .lookup_idx (lookup_idx),
        .lookup_tag (lookup_tag),
        .hit        (hit),
        .hit_way    (hit_way),
        .lru_way    (lru_way),
        .rd_way     (rd_way),
        .rd_valid   (rd_valid),
        .rd_dirty   (rd_dirty),
        .rd_tag     (rd_tag),
        .rd_data0   (rd_data0),
        .rd_data1   (rd_data1),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .wr_way     (wr_way),
        .wr_valid   (wr_valid),
        .wr_dirty   (wr_dirty),
        .wr_tag     (wr_tag),
        .wr_data0   (wr_data0),
        .wr_data1   (wr_data1),
        .wr_lru     (wr_lru)
    );

endmodule

`default_nettype wire

// File: testbench/dcache_properties.sv
// dcache memory bus and CPU handshake assertions, bound into the top level
`timescale 1ns/1ps
`default_nettype none

module dcache_properties import dcache_pkg::*; (
    input logic  CLK,
    input logic  nRST,
    input logic  halt,
    input logic  dhit,
    input logic  flushed,
    input logic  mem_ren,
    input logic  mem_wen,
    input addr_t mem_addr,
    input logic  mem_wait
);

    // one bus direction at a time
    a_one_direction: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_ren && mem_wen))
        else $error("memory read and write requested together");

    a_word_aligned: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_ren || mem_wen) |-> (mem_addr[BYTE_OFF_W-1:0] == '0))
        else $error("memory address not word aligned");

    // back-pressure only stretches the transfer
    a_hold_on_wait: assert property (@(posedge CLK) disable iff (!nRST)
        ((mem_ren || mem_wen) && mem_wait)
            |=> ($stable(mem_addr) && $stable(mem_ren) && $stable(mem_wen)))
        else $error("memory request changed while mem_wait was high");

    a_no_hit_on_halt: assert property (@(posedge CLK) disable iff (!nRST)
        halt |-> !dhit)
        else $error("dhit high while halt is high");

    a_quiet_after_reset: assert property (@(posedge CLK)
        $rose(nRST) |-> (!mem_ren && !mem_wen && !flushed))
        else $error("bus request or flushed high right after reset");

endmodule

bind dcache_top dcache_properties u_properties (
    .CLK      (CLK),
    .nRST     (nRST),
    .halt     (halt),
    .dhit     (dhit),
    .flushed  (flushed),
    .mem_ren  (mem_ren),
    .mem_wen  (mem_wen),
    .mem_addr (mem_addr),
    .mem_wait (mem_wait)
);

`default_nettype wire

// File: testbench/dcache_checker.sv
// dcache checker comparing loads, bus write-backs and the flushed image with a reference memory
`timescale 1ns/1ps
`default_nettype none

module dcache_checker import dcache_pkg::*; (
    input  logic  CLK,
    input  logic  nRST,
    input  logic  dmem_ren,
    input  logic  dmem_wen,
    input  addr_t dmem_addr,
    input  word_t dmem_store,
    input  logic  halt,
    input  logic  dhit,
    input  word_t dmem_load,
    input  logic  flushed,
    input  logic  mem_ren,
    input  logic  mem_wen,
    input  addr_t mem_addr,
    input  word_t mem_store,
    input  logic  mem_wait,
    output int    mismatch_count,
    output int    fail_count,
    output logic  compare_done
);

    // five tags per set and two words per block
    localparam int MEM_WORDS = 5 * NUM_SETS * 2;
    localparam int BLK_LSB   = BYTE_OFF_W + BLK_OFF_W;

    word_t ref_mem [MEM_WORDS];
    // what the bus has written so far
    word_t bus_mem [MEM_WORDS];
    logic  busy;
    logic  last_valid;
    logic  [ADDR_W-1:BLK_LSB] last_blk;
    logic  flushed_seen;

    function automatic word_t initial_word(addr_t addr);
        return (addr * 32'h9e37_79b1) ^ 32'h3c5a_96e1;
    endfunction

    initial begin
        mismatch_count = 0;
        fail_count     = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = initial_word(addr_t'(i << BYTE_OFF_W));
            bus_mem[i] = ref_mem[i];
        end
    end

    task automatic compare_image();
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (bus_mem[i] !== ref_mem[i]) begin
                mismatch_count++;
                $display("Mismatch at %0t ns: word 0x%08h holds %08h after flush, expected %08h",
                         $time, i << BYTE_OFF_W, bus_mem[i], ref_mem[i]);
            end
        end
    endtask

    always @(posedge CLK) begin : watch
        int idx;
        if (!nRST) begin
            busy         = 1'b0;
            last_valid   = 1'b0;
            flushed_seen = 1'b0;
            compare_done = 1'b0;
        end else begin
            // the block just used is MRU and must hit at once unless halted
            if ((dmem_ren || dmem_wen) && !busy && !halt && last_valid
                    && dmem_addr[ADDR_W-1:BLK_LSB] == last_blk) begin
                if (!dhit || mem_ren || mem_wen) begin
                    fail_count++;
                    $display("Error at %0t ns: repeat access to 0x%08h did not hit at once",
                             $time, dmem_addr);
                end
            end
            busy = (dmem_ren || dmem_wen) && !dhit;
            if (dhit) begin
                idx = int'(dmem_addr[ADDR_W-1:BYTE_OFF_W]);
                if (idx >= MEM_WORDS) begin
                    fail_count++;
                    $display("Error at %0t ns: CPU address 0x%08h is outside the window",
                             $time, dmem_addr);
                end else if (dmem_ren && dmem_load !== ref_mem[idx]) begin
                    mismatch_count++;
                    $display("Mismatch at %0t ns: load from 0x%08h returned %08h, expected %08h",
                             $time, dmem_addr, dmem_load, ref_mem[idx]);
                end else if (dmem_wen) begin
                    ref_mem[idx] = dmem_store;
                end
                last_valid = 1'b1;
                last_blk   = dmem_addr[ADDR_W-1:BLK_LSB];
            end
            if (mem_wen && !mem_wait) begin
                idx = int'(mem_addr[ADDR_W-1:BYTE_OFF_W]);
                if (idx >= MEM_WORDS) begin
                    fail_count++;
                    $display("Error at %0t ns: write-back to 0x%08h is outside the window",
                             $time, mem_addr);
                end else begin
                    if (mem_store !== ref_mem[idx]) begin
                        mismatch_count++;
                        $display({"Mismatch at %0t ns: write-back to 0x%08h carried %08h,",
                                  " expected %08h"},
                                 $time, mem_addr, mem_store, ref_mem[idx]);
                    end
                    bus_mem[idx] = mem_store;
                end
            end
            if (flushed) begin
                if (!flushed_seen) begin
                    compare_image();
                    compare_done = 1'b1;
                end
                flushed_seen = 1'b1;
            end else if (flushed_seen) begin
                fail_count++;
                $display("Error at %0t ns: flushed fell after it had risen", $time);
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_dcache.sv
// dcache testbench top with clock, reset, random CPU traffic and a memory bus responder
`timescale 1ns/1ps
`default_nettype none

module tb_dcache import dcache_pkg::*; ();

    // five tags per set and two words per block
    localparam int NUM_TAGS      = 5;
    localparam int MEM_WORDS     = NUM_TAGS * NUM_SETS * 2;
    localparam int NUM_REQS      = 2000;
    localparam int REQ_TIMEOUT   = 200;
    localparam int FLUSH_TIMEOUT = 4000;
    localparam int DONE_TIMEOUT  = 20;
    localparam int BLK_SHIFT     = BYTE_OFF_W;
    localparam int IDX_SHIFT     = BYTE_OFF_W + BLK_OFF_W;
    localparam int TAG_SHIFT     = BYTE_OFF_W + BLK_OFF_W + IDX_W;

    logic   CLK;
    logic   nRST;
    logic   dmem_ren;
    logic   dmem_wen;
    addr_t  dmem_addr;
    word_t  dmem_store;
    logic   halt;
    logic   dhit;
    word_t  dmem_load;
    logic   flushed;
    logic   mem_ren;
    logic   mem_wen;
    addr_t  mem_addr;
    word_t  mem_store;
    word_t  mem_load;
    logic   mem_wait;

    int     mismatch_count;
    int     fail_count;
    logic   compare_done;
    int     timeout_count;
    integer cpu_seed;
    integer bus_seed;
    addr_t  last_addr;
    word_t  mem [MEM_WORDS];

    dcache_top u_dcache_top (.*);

    dcache_checker u_checker (.*);

    function automatic word_t initial_word(addr_t addr);
        return (addr * 32'h9e37_79b1) ^ 32'h3c5a_96e1;
    endfunction

    initial begin : clock_gen
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // random read or write that sometimes reuses the block just used
    task automatic issue_request();
        int unsigned tag;
        int unsigned idx;
        int unsigned blk;
        int unsigned kind;
        kind = $unsigned($random(cpu_seed)) % 8;
        tag  = $unsigned($random(cpu_seed)) % NUM_TAGS;
        idx  = $unsigned($random(cpu_seed)) % NUM_SETS;
        blk  = $unsigned($random(cpu_seed)) % 2;
        if (kind < 2) begin
            dmem_addr = {last_addr[ADDR_W-1:IDX_SHIFT], blk[0], 2'b00};
        end else begin
            dmem_addr = addr_t'((tag << TAG_SHIFT) | (idx << IDX_SHIFT) | (blk << BLK_SHIFT));
        end
        dmem_store = $random(cpu_seed);
        dmem_ren   = kind[0];
        dmem_wen   = !kind[0];
        last_addr  = dmem_addr;
    endtask

    task automatic wait_for_hit(output logic timed_out);
        int cycles;
        cycles = 0;
        do begin
            @(posedge CLK);
            cycles++;
        end while (!dhit && cycles < REQ_TIMEOUT);
        timed_out = !dhit;
        if (timed_out) begin
            timeout_count++;
            $display("Timeout: no dhit within %0d cycles for address 0x%08h",
                     REQ_TIMEOUT, dmem_addr);
        end
    endtask

    initial begin : stimulus
        int   cycles;
        logic stop;
        // DUT inputs start idle with reset held
        nRST       = 1'b0;
        dmem_ren   = 1'b0;
        dmem_wen   = 1'b0;
        dmem_addr  = '0;
        dmem_store = '0;
        halt       = 1'b0;
        mem_load   = '0;
        mem_wait   = 1'b1;
        cpu_seed      = 32'h766f4e65;
        bus_seed      = 32'h766f4e65 ^ 32'h5555_aaaa;
        timeout_count = 0;
        last_addr     = '0;
        stop          = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = initial_word(addr_t'(i << BYTE_OFF_W));
        end
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        for (int n = 0; n < NUM_REQS && !stop; n++) begin
            @(negedge CLK);
            issue_request();
            wait_for_hit(stop);
            // an idle cycle now and then
            if (!stop && ($unsigned($random(cpu_seed)) % 8) == 0) begin
                @(negedge CLK);
                dmem_ren = 1'b0;
                dmem_wen = 1'b0;
            end
        end
        if (!stop) begin
            // the block just used is still cached so only halt keeps dhit low
            @(negedge CLK);
            dmem_addr = last_addr;
            dmem_ren  = 1'b1;
            dmem_wen  = 1'b0;
            halt      = 1'b1;
            cycles    = 0;
            do begin
                @(posedge CLK);
                cycles++;
            end while (!flushed && cycles < FLUSH_TIMEOUT);
            if (!flushed) begin
                timeout_count++;
                $display("Timeout: flushed did not rise within %0d cycles", FLUSH_TIMEOUT);
            end else begin
                cycles = 0;
                do begin
                    @(posedge CLK);
                    cycles++;
                end while (!compare_done && cycles < DONE_TIMEOUT);
                if (!compare_done) begin
                    timeout_count++;
                    $display("Timeout: checker never compared the flushed memory");
                end
                // flushed must hold for the rest of the run
                repeat (8) @(posedge CLK);
            end
        end
        $display("Errors: %0d mismatches, %0d other failures, %0d timeouts",
                 mismatch_count, fail_count, timeout_count);
        if (mismatch_count + fail_count + timeout_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // mem_wait drops after 0 to 3 extra cycles
    initial begin : responder
        int    extra;
        int    idx;
        word_t wdata;
        logic  is_write;
        forever begin
            @(negedge CLK);
            mem_wait = 1'b1;
            if (nRST && (mem_ren || mem_wen)) begin
                extra = $unsigned($random(bus_seed)) % 4;
                repeat (extra) @(negedge CLK);
                idx      = int'(mem_addr[ADDR_W-1:BYTE_OFF_W]);
                is_write = mem_wen;
                wdata    = mem_store;
                mem_load = (idx < MEM_WORDS) ? mem[idx] : '0;
                mem_wait = 1'b0;
                // the transfer completes at this edge
                @(posedge CLK);
                if (is_write && idx < MEM_WORDS) begin
                    mem[idx] = wdata;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: filelist.f
design/dcache_pkg.sv
design/dcache_array.sv
design/dcache_ctrl.sv
design/dcache_top.sv
testbench/dcache_properties.sv
testbench/dcache_checker.sv
testbench/tb_dcache.sv

// File: run.sh
#!/bin/sh
# build the dcache testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache \
    -f filelist.f -o sim_dcache || { echo "build failed"; exit 1; }
out=$(./obj_dir/sim_dcache)
echo "$out"
echo "$out" | grep -q "Simulation PASSED" && echo "run ok" || { echo "run not ok"; exit 1; }
